// File: Makefile
# Verilator flow for the APB UART testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_apb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
uart_cfg_pkg.sv
uart_reg_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_tx_unit.sv
uart_rx.sv
uart_apb_regs.sv
uart_apb_top.sv
uart_tx_unit_asserts.sv
tb_uart_apb.sv

// File: tb_uart_apb.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_apb;

    import uart_cfg_pkg::*;
    import uart_reg_pkg::*;

    // short bit period keeps frames at 80 clocks
    localparam int HALF_BIT     = 4;
    localparam int BIT_CLKS     = 2 * HALF_BIT;
    localparam int FRAME_CLKS   = 10 * BIT_CLKS;
    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 5;
    localparam int SAMPLE_DLY   = 40;
    localparam int TBL_LEN      = 8;
    localparam int POLL_LIMIT   = (FIFO_DEPTH + 2) * FRAME_CLKS;
    // table frames plus two runs of FIFO_DEPTH + 1 frames
    localparam int TOTAL_FRAMES = TBL_LEN + 2 * (FIFO_DEPTH + 1);
    localparam int WDOG_NS      = (TOTAL_FRAMES * 12 * BIT_CLKS + 1000) * CLK_PERIOD;
    localparam logic [31:0] LFSR_SEED = 32'h52718e7a;
    localparam logic [31:0] LFSR_TAPS = 32'hA3000000;

    // one table row: byte, drive by hand, stop bit level, expected frame_err
    typedef struct packed {
        tx_byte_t data;
        logic     manual;
        logic     stop;
        logic     exp_err;
    } row_t;

    logic                  clk;
    logic                  rstn;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  rxd;
    logic                  txd;
    logic                  loopback;
    logic                  rxd_man;
    logic [31:0]           lfsr_state;
    row_t                  rows [TBL_LEN];
    tx_byte_t              exp_q [$];

    // serial line, txd looped back unless the bench drives rxd itself
    assign rxd = loopback ? txd : rxd_man;

    uart_apb_top #(
        .CLK_PER_HALF_BIT (HALF_BIT)
    ) dut (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .rxd     (rxd),
        .txd     (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting and compares
    ////////////////////////////////////////////////////////////////////////////

    task automatic end_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %0b got %0b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [APB_DATA_W-1:0] exp,
                              input logic [APB_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_entry(input string name, input rx_entry_t exp, input rx_entry_t act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    // galois form, one step per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic random_byte(output tx_byte_t b);
        for (int i = 0; i < DATA_BITS; i++) begin
            b[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // apb transfers, setup then access, outputs sampled mid access cycle
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] data, output logic err);
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        #SAMPLE_DLY;
        check_bit("pready", 1'b1, pready);
        err = pslverr;
        // transfer ends on this edge
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                            output logic [APB_DATA_W-1:0] data, output logic err);
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        #SAMPLE_DLY;
        check_bit("pready", 1'b1, pready);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_status(output logic [APB_DATA_W-1:0] st);
        logic err;
        apb_read(REG_STATUS, st, err);
        check_bit("pslverr", 1'b0, err);
    endtask

    // poll one status bit, bounded
    task automatic wait_status(input int pos, input logic val);
        logic [APB_DATA_W-1:0] st;
        for (int n = 0; n < POLL_LIMIT; n++) begin
            read_status(st);
            if (st[pos] === val) break;
        end
        if (st[pos] !== val) begin
            $display("ERROR t=%0t status bit %0d never reached %0b", $time, pos, val);
            end_with_failure();
        end
    endtask

    // empty queue first, busy can blink low between frames
    task automatic wait_tx_idle();
        wait_status(ST_TX_EMPTY, 1'b1);
        wait_status(ST_TX_BUSY, 1'b0);
    endtask

    task automatic send_byte(input tx_byte_t b);
        logic err;
        wait_status(ST_TX_FULL, 1'b0);
        apb_write(REG_TXDATA, APB_DATA_W'(b), err);
        check_bit("pslverr", 1'b0, err);
        exp_q.push_back(b);
    endtask

    // bits above the entry read as zero
    task automatic pop_entry(output rx_entry_t e);
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        apb_read(REG_RXDATA, rd, err);
        check_bit("pslverr", 1'b0, err);
        check_word("prdata[31:9]", '0, APB_DATA_W'(rd[APB_DATA_W-1:9]));
        e = rd[8:0];
    endtask

    // next expected byte against the head of the rx queue
    task automatic check_next_rx();
        rx_entry_t got;
        rx_entry_t exp;
        pop_entry(got);
        exp.data      = exp_q.pop_front();
        exp.frame_err = 1'b0;
        check_entry("rxdata", exp, got);
    endtask

    task automatic send_bit(input logic v);
        @(posedge clk);
        #DRIVE_DLY;
        rxd_man = v;
        repeat (BIT_CLKS - 1) @(posedge clk);
    endtask

    // hand driven frame, the stop level is a choice
    task automatic drive_frame(input tx_byte_t b, input logic stop);
        loopback = 1'b0;
        send_bit(1'b0);
        for (int i = 0; i < DATA_BITS; i++) begin
            send_bit(b[i]);
        end
        send_bit(stop);
        send_bit(1'b1);
        loopback = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        #(WDOG_NS);
        $display("ERROR t=%0t watchdog expired before the tests finished", $time);
        end_with_failure();
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        tx_byte_t              b;
        rx_entry_t             got;
        rx_entry_t             exp;

        rstn       = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        loopback   = 1'b0;
        rxd_man    = 1'b1;
        lfsr_state = LFSR_SEED;
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rstn     = 1'b1;
        loopback = 1'b1;

        // reset state, only the two empty flags up
        read_status(rd);
        check_word("status", APB_DATA_W'((1 << ST_TX_EMPTY) | (1 << ST_RX_EMPTY)), rd);
        repeat (16) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_bit("txd", 1'b1, txd);
        end

        // bus errors
        apb_read(REG_RXDATA, rd, err);
        check_bit("pslverr", 1'b1, err);
        check_word("prdata", '0, rd);
        apb_write(4'hC, 32'h1, err);
        check_bit("pslverr", 1'b1, err);
        apb_read(4'hC, rd, err);
        check_bit("pslverr", 1'b1, err);
        apb_write(REG_RXDATA, 32'h5a, err);
        check_bit("pslverr", 1'b1, err);
        apb_read(REG_TXDATA, rd, err);
        check_bit("pslverr", 1'b1, err);
        // bad accesses leave both queues alone
        read_status(rd);
        check_word("status", APB_DATA_W'((1 << ST_TX_EMPTY) | (1 << ST_RX_EMPTY)), rd);

        // loopback and framing table, last rows filled from the lfsr
        rows[0] = '{8'h00, 1'b0, 1'b1, 1'b0};
        rows[1] = '{8'hff, 1'b0, 1'b1, 1'b0};
        rows[2] = '{8'h55, 1'b0, 1'b1, 1'b0};
        rows[3] = '{8'ha5, 1'b1, 1'b0, 1'b1};
        rows[4] = '{8'haa, 1'b0, 1'b1, 1'b0};
        rows[5] = '{8'h3c, 1'b1, 1'b1, 1'b0};
        random_byte(b);
        rows[6] = '{b, 1'b0, 1'b1, 1'b0};
        random_byte(b);
        rows[7] = '{b, 1'b0, 1'b1, 1'b0};

        for (int i = 0; i < TBL_LEN; i++) begin
            if (rows[i].manual) begin
                drive_frame(rows[i].data, rows[i].stop);
            end else begin
                apb_write(REG_TXDATA, APB_DATA_W'(rows[i].data), err);
                check_bit("pslverr", 1'b0, err);
            end
            wait_status(ST_RX_EMPTY, 1'b0);
            pop_entry(got);
            exp.data      = rows[i].data;
            exp.frame_err = rows[i].exp_err;
            check_entry("rxdata", exp, got);
        end

        // back-pressure
        // serializer pulls the first byte out at once, FIFO_DEPTH + 1 fill the queue
        wait_tx_idle();
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            random_byte(b);
            apb_write(REG_TXDATA, APB_DATA_W'(b), err);
            check_bit("pslverr", 1'b0, err);
            exp_q.push_back(b);
        end
        read_status(rd);
        check_bit("tx_full", 1'b1, rd[ST_TX_FULL]);
        random_byte(b);
        apb_write(REG_TXDATA, APB_DATA_W'(b), err);
        check_bit("pslverr", 1'b1, err);
        while (exp_q.size() > 0) begin
            wait_status(ST_RX_EMPTY, 1'b0);
            check_next_rx();
        end
        // dropped byte never shows up
        wait_tx_idle();
        read_status(rd);
        check_bit("rx_empty", 1'b1, rd[ST_RX_EMPTY]);

        // overrun, rx queue left unread
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            random_byte(b);
            send_byte(b);
        end
        wait_status(ST_OVERRUN, 1'b1);
        read_status(rd);
        check_bit("rx_full", 1'b1, rd[ST_RX_FULL]);
        check_bit("overrun", 1'b1, rd[ST_OVERRUN]);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            check_next_rx();
        end
        read_status(rd);
        check_bit("rx_empty", 1'b1, rd[ST_RX_EMPTY]);
        check_bit("overrun", 1'b1, rd[ST_OVERRUN]);
        // write one to clear
        apb_write(REG_STATUS, APB_DATA_W'(1 << ST_OVERRUN), err);
        check_bit("pslverr", 1'b0, err);
        read_status(rd);
        check_bit("overrun", 1'b0, rd[ST_OVERRUN]);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module uart_apb_regs (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [uart_reg_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [uart_reg_pkg::APB_DATA_W-1:0] pwdata,
    output logic [uart_reg_pkg::APB_DATA_W-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                tx_wr_en,
    output uart_cfg_pkg::tx_byte_t              tx_din,
    input  logic                                tx_full,
    input  logic                                tx_empty,
    input  logic                                tx_busy,
    output logic                                rx_pop,
    input  uart_cfg_pkg::rx_entry_t             rx_dout,
    input  logic                                rx_empty,
    input  logic                                rx_full,
    input  logic                                rx_push
);

    import uart_cfg_pkg::*;
    import uart_reg_pkg::*;

    logic                  access;
    logic                  wr_acc;
    logic                  rd_acc;
    logic                  sel_tx;
    logic                  sel_rx;
    logic                  sel_st;
    logic                  overrun;
    logic [APB_DATA_W-1:0] status;

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////

    // no wait states, access phase closes every transfer
    assign pready = 1'b1;
    assign access = psel && penable;
    assign wr_acc = access && pwrite;
    assign rd_acc = access && !pwrite;

    assign sel_tx = (paddr == REG_TXDATA);
    assign sel_rx = (paddr == REG_RXDATA);
    assign sel_st = (paddr == REG_STATUS);

    // strobes only for legal accesses
    assign tx_wr_en = wr_acc && sel_tx && !tx_full;
    assign tx_din   = pwdata[DATA_BITS-1:0];
    assign rx_pop   = rd_acc && sel_rx && !rx_empty;

    // bad direction, empty/full queue, or unmapped offset
    assign pslverr = access && ((sel_tx && (!pwrite || tx_full))
                             || (sel_rx && (pwrite || rx_empty))
                             || !(sel_tx || sel_rx || sel_st));

    ////////////////////////////////////////////////////////////////////////////
    // status and read data
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        status              = '0;
        status[ST_TX_FULL]  = tx_full;
        status[ST_TX_EMPTY] = tx_empty;
        status[ST_TX_BUSY]  = tx_busy;
        status[ST_RX_EMPTY] = rx_empty;
        status[ST_RX_FULL]  = rx_full;
        status[ST_OVERRUN]  = overrun;
    end

    // rx queue head is registered, so it is valid in the access cycle
    always_comb begin
        prdata = '0;
        if (rd_acc) begin
            if (sel_rx && !rx_empty) begin
                prdata = APB_DATA_W'(rx_dout);
            end else if (sel_st) begin
                prdata = status;
            end
        end
    end

    // sticky overrun, a new drop wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            overrun <= 1'b0;
        end else if (rx_push && rx_full) begin
            overrun <= 1'b1;
        end else if (wr_acc && sel_st && pwdata[ST_OVERRUN]) begin
            overrun <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: uart_apb_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_apb_top #(
    parameter int CLK_PER_HALF_BIT = uart_cfg_pkg::CLK_PER_HALF_BIT_DEF
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [uart_reg_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [uart_reg_pkg::APB_DATA_W-1:0] pwdata,
    output logic [uart_reg_pkg::APB_DATA_W-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  logic                                rxd,
    output logic                                txd
);

    import uart_cfg_pkg::*;

    // register block to transmit unit
    logic      tx_wr_en;
    tx_byte_t  tx_din;
    logic      tx_full;
    logic      tx_empty;
    logic      tx_busy;

    // receiver and receive queue
    logic      rx_push;
    rx_entry_t rx_entry;
    logic      rx_pop;
    rx_entry_t rx_dout;
    logic      rx_empty;
    logic      rx_full;

    uart_apb_regs regs (
        .clk      (clk),
        .rstn     (rstn),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .tx_wr_en (tx_wr_en),
        .tx_din   (tx_din),
        .tx_full  (tx_full),
        .tx_empty (tx_empty),
        .tx_busy  (tx_busy),
        .rx_pop   (rx_pop),
        .rx_dout  (rx_dout),
        .rx_empty (rx_empty),
        .rx_full  (rx_full),
        .rx_push  (rx_push)
    );

    uart_tx_unit #(
        .CLK_PER_HALF_BIT (CLK_PER_HALF_BIT)
    ) tx_unit (
        .clk   (clk),
        .rstn  (rstn),
        .wr_en (tx_wr_en),
        .din   (tx_din),
        .full  (tx_full),
        .empty (tx_empty),
        .busy  (tx_busy),
        .txd   (txd)
    );

    uart_rx #(
        .CLK_PER_HALF_BIT (CLK_PER_HALF_BIT)
    ) rx (
        .clk   (clk),
        .rstn  (rstn),
        .rxd   (rxd),
        .push  (rx_push),
        .entry (rx_entry)
    );

    // push on full is dropped here, regs flags the overrun
    uart_fifo #(
        .DEPTH   (FIFO_DEPTH),
        .entry_t (rx_entry_t)
    ) rx_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .wr_en (rx_push),
        .din   (rx_entry),
        .rd_en (rx_pop),
        .dout  (rx_dout),
        .full  (rx_full),
        .empty (rx_empty)
    );

endmodule

`default_nettype wire

// File: uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

    // frame geometry, 8N1 only
    localparam int DATA_BITS = 8;

    // entries per queue, same for tx and rx
    localparam int FIFO_DEPTH = 8;

    // 100 MHz clock at 115200 baud, half of 868 clocks per bit
    localparam int CLK_PER_HALF_BIT_DEF = 434;

    // one payload byte on the wire
    typedef logic [DATA_BITS-1:0] tx_byte_t;

    // receive queue entry
    // bit 8 flags a low stop bit, bits 7:0 the byte
    typedef struct packed {
        logic     frame_err;
        tx_byte_t data;
    } rx_entry_t;

endpackage

`default_nettype wire

// File: uart_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module uart_fifo #(
    parameter int  DEPTH   = uart_cfg_pkg::FIFO_DEPTH,
    parameter type entry_t = uart_cfg_pkg::tx_byte_t
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   wr_en,
    input  entry_t din,
    input  logic   rd_en,
    output entry_t dout,
    output logic   full,
    output logic   empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    logic             do_wr;
    logic             do_rd;

    // wrap at DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // push on full and pop on empty are dropped here
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign rd_ptr_nxt = do_rd ? ptr_inc(rd_ptr) : rd_ptr;
    assign count_nxt  = count + CNT_W'(do_wr) - CNT_W'(do_rd);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            rd_ptr <= rd_ptr_nxt;
            count  <= count_nxt;
            // flags from next count, so they are registered and exact
            full   <= (count_nxt == CNT_W'(DEPTH));
            empty  <= (count_nxt == '0);
        end
    end

    // storage and head register
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        // write landing on the next head goes straight to dout
        if (do_wr && (wr_ptr == rd_ptr_nxt)) begin
            dout <= din;
        end else begin
            dout <= mem[rd_ptr_nxt];
        end
    end

endmodule

`default_nettype wire

// File: uart_reg_pkg.sv
`default_nettype none

package uart_reg_pkg;

    // apb bus widths
    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;

    ////////////////////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////////////////////

    // write only, pushes one byte into the tx queue
    localparam logic [APB_ADDR_W-1:0] REG_TXDATA = 4'h0;

    // read only, pops one rx entry
    localparam logic [APB_ADDR_W-1:0] REG_RXDATA = 4'h4;

    // queue flags plus sticky overrun, write 1 to clear overrun
    localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'h8;

    ////////////////////////////////////////////////////////////////////////////
    // status bit positions
    ////////////////////////////////////////////////////////////////////////////

    localparam int ST_TX_FULL  = 0;
    localparam int ST_TX_EMPTY = 1;
    // serializer or fetch in progress
    localparam int ST_TX_BUSY  = 2;
    localparam int ST_RX_EMPTY = 3;
    localparam int ST_RX_FULL  = 4;
    // sticky, rx entry dropped on a full queue
    localparam int ST_OVERRUN  = 5;

endpackage

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
    parameter int CLK_PER_HALF_BIT = uart_cfg_pkg::CLK_PER_HALF_BIT_DEF
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    rxd,
    output logic                    push,
    output uart_cfg_pkg::rx_entry_t entry
);

    import uart_cfg_pkg::*;

    localparam int BIT_CLKS = 2 * CLK_PER_HALF_BIT;
    localparam int CNT_W    = $clog2(BIT_CLKS);
    localparam int IDX_W    = (DATA_BITS > 1) ? $clog2(DATA_BITS) : 1;

    typedef enum logic [1:0] {
        R_IDLE,
        R_START,
        R_DATA,
        R_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_prev;
    logic [CNT_W-1:0] cnt;
    logic [IDX_W-1:0] bit_idx;
    tx_byte_t         shreg;
    logic             half_mark;
    logic             bit_mark;

    assign half_mark = (cnt == CNT_W'(CLK_PER_HALF_BIT - 1));
    assign bit_mark  = (cnt == CNT_W'(BIT_CLKS - 1));

    // two flop synchronizer plus edge history
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if ((state == R_DATA) && bit_mark) begin
            shreg <= {rxd_sync, shreg[DATA_BITS-1:1]};
        end
    end

    // entry built at mid stop bit
    always_ff @(posedge clk) begin
        if ((state == R_STOP) && bit_mark) begin
            entry.data      <= shreg;
            entry.frame_err <= !rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= R_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            push    <= 1'b0;
        end else begin
            push <= 1'b0;
            cnt  <= cnt + 1'b1;
            case (state)
                R_IDLE: begin
                    cnt <= '0;
                    // falling edge starts a frame
                    if (rxd_prev && !rxd_sync) begin
                        state <= R_START;
                    end
                end
                R_START: begin
                    if (half_mark) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // start bit gone high at its middle, glitch
                        state   <= rxd_sync ? R_IDLE : R_DATA;
                    end
                end
                R_DATA: begin
                    if (bit_mark) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(DATA_BITS - 1)) begin
                            state <= R_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_mark) begin
                        push  <= 1'b1;
                        state <= R_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
    parameter int CLK_PER_HALF_BIT = uart_cfg_pkg::CLK_PER_HALF_BIT_DEF
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  uart_cfg_pkg::tx_byte_t sdata,
    input  logic                  tx_start,
    output logic                  tx_busy,
    output logic                  txd
);

    import uart_cfg_pkg::*;

    localparam int CNT_W = (CLK_PER_HALF_BIT > 1) ? $clog2(CLK_PER_HALF_BIT) : 1;
    // start, data bits, stop
    localparam int IDX_W = $clog2(DATA_BITS + 2);

    logic [CNT_W-1:0] half_cnt;
    logic             second_half;
    logic [IDX_W-1:0] bit_idx;
    tx_byte_t         shreg;
    logic             half_done;

    assign half_done = (half_cnt == CNT_W'(CLK_PER_HALF_BIT - 1));

    // payload shifter, loaded on start, shifted at each data bit boundary
    always_ff @(posedge clk) begin
        if (tx_start && !tx_busy) begin
            shreg <= sdata;
        end else if (tx_busy && half_done && second_half && (bit_idx < IDX_W'(DATA_BITS))) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_busy     <= 1'b0;
            txd         <= 1'b1;
            half_cnt    <= '0;
            second_half <= 1'b0;
            bit_idx     <= '0;
        end else if (!tx_busy) begin
            // idle line stays high until a start request
            if (tx_start) begin
                tx_busy     <= 1'b1;
                txd         <= 1'b0;
                half_cnt    <= '0;
                second_half <= 1'b0;
                bit_idx     <= '0;
            end
        end else if (half_done) begin
            half_cnt    <= '0;
            second_half <= !second_half;
            // end of a full bit time
            if (second_half) begin
                if (bit_idx == IDX_W'(DATA_BITS + 1)) begin
                    // stop bit done, line already high
                    tx_busy <= 1'b0;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                    // data lsb first, then stop
                    txd     <= (bit_idx < IDX_W'(DATA_BITS)) ? shreg[0] : 1'b1;
                end
            end
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: uart_tx_unit.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_unit #(
    parameter int CLK_PER_HALF_BIT = uart_cfg_pkg::CLK_PER_HALF_BIT_DEF
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   wr_en,
    input  uart_cfg_pkg::tx_byte_t din,
    output logic                   full,
    output logic                   empty,
    output logic                   busy,
    output logic                   txd
);

    import uart_cfg_pkg::*;

    typedef enum logic [1:0] {
        F_IDLE,
        F_READ,
        F_START
    } fetch_t;

    fetch_t   state;
    logic     rd_en;
    logic     tx_start;
    logic     tx_busy;
    tx_byte_t q_head;
    tx_byte_t sdata;

    uart_fifo #(
        .DEPTH   (FIFO_DEPTH),
        .entry_t (tx_byte_t)
    ) tx_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .wr_en (wr_en),
        .din   (din),
        .rd_en (rd_en),
        .dout  (q_head),
        .full  (full),
        .empty (empty)
    );

    uart_tx #(
        .CLK_PER_HALF_BIT (CLK_PER_HALF_BIT)
    ) tx (
        .clk      (clk),
        .rstn     (rstn),
        .sdata    (sdata),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .txd      (txd)
    );

    ////////////////////////////////////////////////////////////////////////////
    // fetch sequencer
    // idle -> read (rd_en) -> start (tx_start) -> idle
    ////////////////////////////////////////////////////////////////////////////

    // head moves on at the pop, so hold the popped byte for the serializer
    always_ff @(posedge clk) begin
        if (rd_en) begin
            sdata <= q_head;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= F_IDLE;
            rd_en    <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            rd_en    <= 1'b0;
            tx_start <= 1'b0;
            case (state)
                F_IDLE: begin
                    // back-pressure, wait out the current frame
                    if (!empty && !tx_busy) begin
                        rd_en <= 1'b1;
                        state <= F_READ;
                    end
                end
                F_READ: begin
                    tx_start <= 1'b1;
                    state    <= F_START;
                end
                // one cycle gap, tx_busy is up by the next check
                default: state <= F_IDLE;
            endcase
        end
    end

    // busy over the fetch as well as the frame
    assign busy = tx_busy || (state != F_IDLE);

endmodule

`default_nettype wire

// File: uart_tx_unit_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_unit_asserts (
    input logic clk,
    input logic rstn,
    input logic rd_en,
    input logic tx_start,
    input logic tx_busy,
    input logic empty,
    input logic busy,
    input logic txd
);

    // pop only with something in the queue
    assert property (@(posedge clk) disable iff (!rstn) rd_en |-> !empty)
        else $error("tx fetch popped an empty queue");

    // start only into an idle serializer
    assert property (@(posedge clk) disable iff (!rstn) tx_start |-> !tx_busy)
        else $error("tx start issued while the serializer was busy");

    // idle line is high
    assert property (@(posedge clk) disable iff (!rstn) !busy |-> txd)
        else $error("txd low while the transmit unit was idle");

endmodule

// internal fetch strobes reached by name inside each uart_tx_unit
bind uart_tx_unit uart_tx_unit_asserts tx_unit_chk (
    .clk      (clk),
    .rstn     (rstn),
    .rd_en    (rd_en),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .empty    (empty),
    .busy     (busy),
    .txd      (txd)
);

`default_nettype wire
